// File: src/pool_pkg.sv
package pool_pkg;

  // Output pixel and accumulator widths, both signed
  localparam int WORD_WIDTH = 8;
  localparam int ACC_WIDTH  = 16;

  // Number of lanes every beat struct is sized for
  localparam int MAX_UNITS = 4;

  // Negative slope of the leaky ReLU is 2**-LRELU_SHIFT
  localparam int LRELU_SHIFT = 3;

  // Saturation bounds of a requantized pixel
  localparam int PIX_MAX = (1 << (WORD_WIDTH - 1)) - 1;
  localparam int PIX_MIN = -(1 << (WORD_WIDTH - 1));

  typedef logic signed [ACC_WIDTH-1:0]  acc_t;
  typedef logic signed [WORD_WIDTH-1:0] pix_t;

  // One pixel position of accumulator values from the convolution engine
  typedef struct packed {
    acc_t [MAX_UNITS-1:0] data;
    logic                 last;
  } acc_beat_t;

  // One pixel position of requantized values
  typedef struct packed {
    pix_t [MAX_UNITS-1:0] data;
    logic                 last;
  } pix_beat_t;

  // Lanewise signed maximum, shared by the pooling stage
  function automatic pix_t max_pix(input pix_t a, input pix_t b);
    if (a > b) begin
      max_pix = a;
    end else begin
      max_pix = b;
    end
  endfunction

endpackage

// File: src/lrelu_stage.sv
module lrelu_stage
  import pool_pkg::*;
#(
  parameter int UNITS = MAX_UNITS
) (
  input  logic      aclk,
  input  logic      i_rst_n,
  input  logic      i_valid,
  input  acc_beat_t i_beat,
  output logic      o_ready,
  output logic      o_valid,
  output pix_beat_t o_beat,
  input  logic      i_ready
);

  pix_beat_t next_beat;
  logic      in_fire;

  // Leaky ReLU followed by saturation to the signed pixel range
  function automatic pix_t lrelu_sat(input acc_t value);
    acc_t scaled;
    if (value[ACC_WIDTH-1]) begin
      scaled = value >>> LRELU_SHIFT;
    end else begin
      scaled = value;
    end
    if (scaled > acc_t'(PIX_MAX)) begin
      lrelu_sat = pix_t'(PIX_MAX);
    end else if (scaled < acc_t'(PIX_MIN)) begin
      lrelu_sat = pix_t'(PIX_MIN);
    end else begin
      lrelu_sat = pix_t'(scaled);
    end
  endfunction

  // The output register can take a new beat when it is empty or drains now
  assign o_ready = !o_valid || i_ready;
  assign in_fire = i_valid && o_ready;

  always_comb begin
    next_beat = '0;
    for (int u = 0; u < UNITS; u++) begin
      next_beat.data[u] = lrelu_sat(i_beat.data[u]);
    end
    next_beat.last = i_beat.last;
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_fire) begin
      o_beat <= next_beat;
    end
  end

  // A stalled beat must not change under the downstream FIFO
  a_hold_stable: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_beat)
  ) else $error("lrelu_stage: output beat changed while stalled");

endmodule

// File: src/stream_fifo.sv
module stream_fifo
  import pool_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  logic      aclk,
  input  logic      i_rst_n,
  input  logic      i_wr_valid,
  input  pix_beat_t i_wr_beat,
  output logic      o_wr_ready,
  output logic      o_rd_valid,
  output pix_beat_t o_rd_beat,
  input  logic      i_rd_ready
);

  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

  pix_beat_t            mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   count;
  logic                 wr_en;
  logic                 rd_en;

  assign o_wr_ready = (count != (PTR_WIDTH + 1)'(FIFO_DEPTH));
  assign o_rd_valid = (count != '0);
  assign o_rd_beat  = mem[rd_ptr];

  assign wr_en = i_wr_valid && o_wr_ready;
  assign rd_en = o_rd_valid && i_rd_ready;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_wr_beat;
    end
  end

  a_count_max: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    count <= (PTR_WIDTH + 1)'(FIFO_DEPTH)
  ) else $error("stream_fifo: occupancy above depth");

  // An empty FIFO leaves zero only by a write and never by wrapping down
  a_count_floor: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    count == '0 && !wr_en |=> count == '0
  ) else $error("stream_fifo: occupancy wrapped below zero");

endmodule

// File: src/maxpool_2x2.sv
module maxpool_2x2
  import pool_pkg::*;
#(
  parameter int UNITS    = MAX_UNITS,
  parameter int IM_WIDTH = 8
) (
  input  logic      aclk,
  input  logic      i_rst_n,
  input  logic      i_valid,
  input  pix_beat_t i_beat,
  output logic      o_ready,
  output logic      o_valid,
  output pix_beat_t o_beat,
  input  logic      i_ready
);

  localparam int HALF   = IM_WIDTH / 2;
  localparam int COL_W  = $clog2(IM_WIDTH);
  localparam int HALF_W = (HALF > 1) ? $clog2(HALF) : 1;

  // Column pair maxima of the even row with one entry per output column
  pix_t [MAX_UNITS-1:0] row_mem [HALF];

  pix_t [MAX_UNITS-1:0] held;
  pix_t [MAX_UNITS-1:0] pair_max;
  pix_t [MAX_UNITS-1:0] row_rd;
  pix_beat_t            pooled;

  logic [COL_W-1:0]  col;
  logic [HALF_W-1:0] half_idx;
  logic              row_odd;
  logic              col_odd;
  logic              col_end;
  logic              in_fire;
  logic              out_fire;

  // Input stalls only while a finished window is still waiting downstream
  assign o_ready  = !o_valid || i_ready;
  assign in_fire  = i_valid && o_ready;
  assign out_fire = o_valid && i_ready;

  assign col_odd  = col[0];
  assign col_end  = (col == COL_W'(IM_WIDTH - 1));
  assign half_idx = HALF_W'(col >> 1);
  assign row_rd   = row_mem[half_idx];

  always_comb begin
    pair_max = '0;
    pooled   = '0;
    for (int u = 0; u < UNITS; u++) begin
      pair_max[u]    = max_pix(held[u], i_beat.data[u]);
      pooled.data[u] = max_pix(pair_max[u], row_rd[u]);
    end
    pooled.last = i_beat.last;
  end

  // Raster position tracking where the frame height comes from last
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      col     <= '0;
      row_odd <= 1'b0;
    end else if (in_fire) begin
      if (i_beat.last) begin
        col     <= '0;
        row_odd <= 1'b0;
      end else if (col_end) begin
        col     <= '0;
        row_odd <= !row_odd;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (in_fire && row_odd && col_odd) begin
      o_valid <= 1'b1;
    end else if (out_fire) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_fire) begin
      if (!col_odd) begin
        held <= i_beat.data;
      end else if (!row_odd) begin
        row_mem[half_idx] <= pair_max;
      end else begin
        o_beat <= pooled;
      end
    end
  end

  // Frames must be whole row pairs, so last can only close an odd row
  a_last_pos: assert property (
    @(posedge aclk) disable iff (!i_rst_n)
    in_fire && i_beat.last |-> row_odd && col_end
  ) else $error("maxpool_2x2: last outside the final column of an odd row");

endmodule

// File: src/lrelu_pool_top.sv
module lrelu_pool_top
  import pool_pkg::*;
#(
  parameter int UNITS      = 4,
  parameter int IM_WIDTH   = 8,
  parameter int FIFO_DEPTH = 8
) (
  input  logic      aclk,
  input  logic      i_rst_n,
  input  logic      i_acc_valid,
  input  acc_beat_t i_acc,
  output logic      o_acc_ready,
  output logic      o_pool_valid,
  output pix_beat_t o_pool,
  input  logic      i_pool_ready
);

  logic      lr_valid;
  logic      lr_ready;
  pix_beat_t lr_beat;

  logic      fq_valid;
  logic      fq_ready;
  pix_beat_t fq_beat;

  lrelu_stage #(
    .UNITS (UNITS)
  ) u_lrelu (
    .aclk    (aclk),
    .i_rst_n (i_rst_n),
    .i_valid (i_acc_valid),
    .i_beat  (i_acc),
    .o_ready (o_acc_ready),
    .o_valid (lr_valid),
    .o_beat  (lr_beat),
    .i_ready (lr_ready)
  );

  // Absorbs pooling stalls so the activation stage keeps streaming
  stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_wr_valid (lr_valid),
    .i_wr_beat  (lr_beat),
    .o_wr_ready (lr_ready),
    .o_rd_valid (fq_valid),
    .o_rd_beat  (fq_beat),
    .i_rd_ready (fq_ready)
  );

  maxpool_2x2 #(
    .UNITS    (UNITS),
    .IM_WIDTH (IM_WIDTH)
  ) u_pool (
    .aclk    (aclk),
    .i_rst_n (i_rst_n),
    .i_valid (fq_valid),
    .i_beat  (fq_beat),
    .o_ready (fq_ready),
    .o_valid (o_pool_valid),
    .o_beat  (o_pool),
    .i_ready (i_pool_ready)
  );

endmodule

// File: test/lrelu_pool_model.svh
`ifndef LRELU_POOL_MODEL_SVH
`define LRELU_POOL_MODEL_SVH

// Expected pooled beats in the order the DUT must emit them
pix_beat_t expected_q[$];

// Leaky ReLU with a slope of 1/8, then clamp into the signed 8-bit range
function automatic pix_t ref_activate(input acc_t value);
  int v;
  v = value;
  if (v < 0) begin
    // Arithmetic shift of a signed int floors toward minus infinity
    v = v >>> 3;
  end
  if (v > 127) begin
    v = 127;
  end else if (v < -128) begin
    v = -128;
  end
  return pix_t'(v);
endfunction

// Pools a whole raster frame into expected beats, one per 2x2 window
task automatic model_frame(input acc_beat_t frame[$]);
  int        rows;
  int        idx;
  pix_t      best;
  pix_t      cand;
  pix_beat_t exp_beat;
  rows = frame.size() / IM_WIDTH;
  for (int r = 0; r < rows; r += 2) begin
    for (int c = 0; c < IM_WIDTH; c += 2) begin
      exp_beat = '0;
      for (int u = 0; u < UNITS; u++) begin
        best = ref_activate(frame[r * IM_WIDTH + c].data[u]);
        for (int k = 1; k < 4; k++) begin
          idx  = (r + k / 2) * IM_WIDTH + c + k % 2;
          cand = ref_activate(frame[idx].data[u]);
          if (cand > best) begin
            best = cand;
          end
        end
        exp_beat.data[u] = best;
      end
      exp_beat.last = (r == rows - 2) && (c == IM_WIDTH - 2);
      expected_q.push_back(exp_beat);
    end
  end
endtask

`endif

// File: test/lrelu_pool_tb.sv
module lrelu_pool_tb
  import pool_pkg::*;
();

  localparam int UNITS      = 4;
  localparam int IM_WIDTH   = 8;
  localparam int FIFO_DEPTH = 8;
  localparam int WAIT_LIMIT = 1000;

  `include "lrelu_pool_model.svh"

  logic      aclk;
  logic      i_rst_n;
  logic      i_acc_valid;
  acc_beat_t i_acc;
  logic      o_acc_ready;
  logic      o_pool_valid;
  pix_beat_t o_pool;
  logic      i_pool_ready;

  logic [31:0] rng_src;
  logic [31:0] rng_sink;
  logic        sink_hold;
  acc_beat_t   frame_q[$];
  int          errors;
  int          checks;
  int          out_count;
  int          tests_run;

  lrelu_pool_top #(
    .UNITS      (UNITS),
    .IM_WIDTH   (IM_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (
    .aclk         (aclk),
    .i_rst_n      (i_rst_n),
    .i_acc_valid  (i_acc_valid),
    .i_acc        (i_acc),
    .o_acc_ready  (o_acc_ready),
    .o_pool_valid (o_pool_valid),
    .o_pool       (o_pool),
    .i_pool_ready (i_pool_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_src();
    rng_src = xorshift32(rng_src);
    return rng_src;
  endfunction

  // Mode 0 is non-negative, mode 1 negative, anything else mixed near zero
  function automatic acc_t make_value(input int mode);
    logic [31:0] r;
    int          v;
    r = next_src();
    if (mode == 0) begin
      v = (r[2:0] == 3'd0) ? int'(r[31:16] % 16'd2000) : int'(r[31:16] % 16'd160);
    end else if (mode == 1) begin
      v = (r[1:0] == 2'd0) ? -1 - int'(r[31:17]) : -1 - int'(r[31:16] % 16'd1200);
    end else begin
      v = (r[1:0] == 2'd0) ? int'($signed(r[31:16])) : int'(r[31:16] % 16'd1025) - 512;
    end
    return acc_t'(v);
  endfunction

  task automatic check_beat(input pix_beat_t got, input pix_beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at time %0t: pooled beat %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAILED at time %0t: %0d output beats, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at time %0t: %s", $time, what);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic build_frame(input int mode, inout int exp_beats);
    int        rows;
    acc_beat_t beat;
    rows = 2 * (1 + int'(next_src() % 32'd3));
    frame_q.delete();
    for (int i = 0; i < rows * IM_WIDTH; i++) begin
      beat = '0;
      for (int u = 0; u < UNITS; u++) begin
        beat.data[u] = make_value(mode);
      end
      beat.last = (i == rows * IM_WIDTH - 1);
      frame_q.push_back(beat);
    end
    model_frame(frame_q);
    exp_beats += rows * IM_WIDTH / 4;
  endtask

  // A presented beat stays on the bus until the DUT takes it
  task automatic drive_frame();
    int idx;
    int stall;
    idx   = 0;
    stall = 0;
    while (idx < frame_q.size()) begin
      @(posedge aclk);
      if (i_acc_valid && o_acc_ready) begin
        idx++;
        stall = 0;
      end else begin
        stall++;
        if (stall > WAIT_LIMIT) begin
          abort_on_timeout("input beat never accepted");
        end
      end
      if (idx < frame_q.size() && !(i_acc_valid && !o_acc_ready)) begin
        i_acc_valid <= (next_src() % 32'd4) != 0;
        i_acc       <= frame_q[idx];
      end
    end
    i_acc_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0) begin
      @(posedge aclk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_on_timeout("expected pooled beats never arrived");
      end
    end
    // Give a duplicated beat the chance to show up
    repeat (10) @(posedge aclk);
  endtask

  task automatic run_test(input string name, input int mode, input int frames,
                          input int hold_cycles);
    int err_start;
    int out_start;
    int exp_beats;
    err_start = errors;
    out_start = out_count;
    exp_beats = 0;
    if (hold_cycles > 0) begin
      sink_hold <= 1'b1;
    end
    fork
      begin
        for (int f = 0; f < frames; f++) begin
          build_frame(mode, exp_beats);
          drive_frame();
        end
      end
      begin
        repeat (hold_cycles) @(posedge aclk);
        sink_hold <= 1'b0;
      end
    join
    wait_drain();
    check_count(out_count - out_start, exp_beats);
    tests_run++;
    $display("Test %s finished: %0d frames, %0d errors", name, frames, errors - err_start);
  endtask

  // Sink side checks every accepted beat against the model queue
  always @(posedge aclk) begin
    if (i_rst_n && o_pool_valid && i_pool_ready) begin
      out_count++;
      if (expected_q.size() == 0) begin
        errors++;
        $display("Output beat at time %0t arrived when no beat was expected", $time);
      end else begin
        check_beat(o_pool, expected_q.pop_front());
      end
    end
    rng_sink = xorshift32(rng_sink);
    i_pool_ready <= !sink_hold && (rng_sink[3:0] > 4'd4);
  end

  initial begin
    rng_src      = 32'd28;
    rng_sink     = xorshift32(32'd28) ^ 32'h0000_ffff;
    sink_hold    = 1'b0;
    errors       = 0;
    checks       = 0;
    out_count    = 0;
    tests_run    = 0;
    i_rst_n      = 1'b0;
    i_acc_valid  = 1'b0;
    i_acc        = '0;
    i_pool_ready = 1'b0;

    for (int c = 0; c < 10; c++) begin
      @(posedge aclk);
      if (c > 0) begin
        check_flag(o_pool_valid, 1'b0, "o_pool_valid in reset");
        check_flag(o_acc_ready, 1'b1, "o_acc_ready in reset");
      end
    end
    i_rst_n <= 1'b1;
    @(posedge aclk);
    check_flag(o_pool_valid, 1'b0, "o_pool_valid after reset");
    check_flag(o_acc_ready, 1'b1, "o_acc_ready after reset");
    tests_run++;
    $display("Test reset finished: %0d errors", errors);

    run_test("positive", 0, 2, 0);
    run_test("negative", 1, 2, 0);
    run_test("mixed", 2, 6, 0);
    run_test("backpressure", 2, 3, 300);

    $display("Tests: %0d, checks: %0d, outputs: %0d, errors: %0d",
             tests_run, checks, out_count, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: lrelu_pool_top.f
+incdir+test
src/pool_pkg.sv
src/lrelu_stage.sv
src/stream_fifo.sv
src/maxpool_2x2.sv
src/lrelu_pool_top.sv
test/lrelu_pool_tb.sv
